// File: Makefile
VERILATOR ?= verilator
TOP       ?= asrm_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= STATUS: FAIL

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+hdl
hdl/asrm_isa_pkg.sv
hdl/asrm_core_pkg.sv
hdl/asrm_fetch.sv
hdl/asrm_inst_fifo.sv
hdl/asrm_alu.sv
hdl/asrm_exec.sv
hdl/asrm_top.sv
verification/asrm_tb.sv

// File: hdl/asrm_alu.sv
// ASRM ALU
// result value and destination register

`default_nettype none

`include "asrm_settings.svh"

module asrm_alu (
    input  logic [`ASRM_WORDSIZE-1:0]       working_register,
    input  logic [`ASRM_WORDSIZE-1:0]       other_register,
    input  logic [`ASRM_WORDSIZE-1:0]       status_register,
    input  logic [7:0]                      instruction,
    output asrm_core_pkg::asrm_alu_result_t result
);

    localparam int W = `ASRM_WORDSIZE;

    asrm_isa_pkg::asrm_opcode_e opcode;
    asrm_isa_pkg::asrm_sys_e    sys_op;
    asrm_isa_pkg::asrm_reg_id_t dest_nocmp;
    asrm_isa_pkg::asrm_reg_id_t dest_out;
    logic [W-1:0] add_out;
    logic [W-1:0] sub_out;
    logic [W-1:0] and_out;
    logic [W-1:0] or_out;
    logic [W-1:0] xor_out;
    logic [W-1:0] not_out;
    logic [W-1:0] lsl_out;
    logic [W-1:0] lsr_out;
    logic [W-1:0] raw_out;
    logic [W-1:0] set_out;
    logic [W-1:0] oth_out;
    logic [W-1:0] value_nocmp;
    logic [W-1:0] value_out;
    logic         is_jmp;
    logic         is_jif;
    logic         raw_sel;
    logic         cmp_eq;
    logic         cmp_les;
    logic         cmp_sel;

    assign opcode = asrm_isa_pkg::asrm_opcode_e'(instruction[7:4]);
    assign sys_op = asrm_isa_pkg::asrm_sys_e'(instruction[3:0]);

    assign is_jmp = (opcode == asrm_isa_pkg::op_sys) && (sys_op == asrm_isa_pkg::sys_jmp);
    assign is_jif = (opcode == asrm_isa_pkg::op_sys) && (sys_op == asrm_isa_pkg::sys_jif);

    // every sys instruction and cpy pass WR through untouched
    // unused opcodes behave as nop
    assign raw_sel = (opcode == asrm_isa_pkg::op_sys) || (opcode == asrm_isa_pkg::op_cpy)
                     || (opcode > asrm_isa_pkg::op_les);

    // arithmetic
    assign add_out = (opcode == asrm_isa_pkg::op_add) ? working_register + other_register
                                                      : '0;
    assign sub_out = (opcode == asrm_isa_pkg::op_sub) ? working_register - other_register
                                                      : '0;
    // logic and shifts, large shift amounts fall out as zero
    assign and_out = (opcode == asrm_isa_pkg::op_and) ? working_register & other_register
                                                      : '0;
    assign or_out  = (opcode == asrm_isa_pkg::op_or) ? working_register | other_register
                                                     : '0;
    assign xor_out = (opcode == asrm_isa_pkg::op_xor) ? working_register ^ other_register
                                                      : '0;
    assign not_out = (opcode == asrm_isa_pkg::op_not) ? ~other_register : '0;
    assign lsl_out = (opcode == asrm_isa_pkg::op_lsl) ? working_register << other_register
                                                      : '0;
    assign lsr_out = (opcode == asrm_isa_pkg::op_lsr) ? working_register >> other_register
                                                      : '0;
    // moves
    assign raw_out = raw_sel ? working_register : '0;
    assign set_out = (opcode == asrm_isa_pkg::op_set) ? {{(W-4){1'b0}}, instruction[3:0]}
                                                      : '0;
    assign oth_out = (opcode == asrm_isa_pkg::op_read) ? other_register : '0;

    assign value_nocmp = add_out | sub_out | and_out | or_out | xor_out | not_out
                         | lsl_out | lsr_out | raw_out | set_out | oth_out;

    // untaken jif writes WR back onto itself
    assign dest_nocmp = (opcode == asrm_isa_pkg::op_cpy) ? instruction[3:0]
                      : ((is_jif && status_register[0]) || is_jmp) ? `ASRM_PC_ID
                      : `ASRM_WR_ID;

    // compares only touch status bit 0
    assign cmp_eq  = (opcode == asrm_isa_pkg::op_eq) && (working_register == other_register);
    assign cmp_les = (opcode == asrm_isa_pkg::op_les) && (working_register < other_register);
    assign cmp_sel = (opcode == asrm_isa_pkg::op_eq) || (opcode == asrm_isa_pkg::op_les);

    assign value_out = cmp_sel ? {status_register[W-1:1], cmp_eq | cmp_les} : value_nocmp;
    assign dest_out  = cmp_sel ? `ASRM_SR_ID : dest_nocmp;
    assign result    = {value_out, dest_out};

endmodule

`default_nettype wire

// File: hdl/asrm_core_pkg.sv
// ASRM inter-block types

`default_nettype none

`include "asrm_settings.svh"

package asrm_core_pkg;

    // one prefetch queue entry
    typedef struct packed {
        logic [7:0]               inst;
        logic [`ASRM_PROG_AW-1:0] addr;
    } asrm_fetch_item_t;

    // new fetch address on a program counter write
    typedef struct packed {
        logic [`ASRM_PROG_AW-1:0] addr;
    } asrm_redirect_t;

    // value to write back and where it goes
    typedef struct packed {
        logic [`ASRM_WORDSIZE-1:0]  value;
        asrm_isa_pkg::asrm_reg_id_t dest;
    } asrm_alu_result_t;

    // program load write
    typedef struct packed {
        logic [`ASRM_PROG_AW-1:0] addr;
        logic [7:0]               inst;
    } asrm_prog_write_t;

endpackage

`default_nettype wire

// File: hdl/asrm_exec.sv
// ASRM execute stage
// register file, write-back and control outputs

`default_nettype none

`include "asrm_settings.svh"

module asrm_exec (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  asrm_core_pkg::asrm_fetch_item_t head,
    input  logic                            not_empty,
    output logic                            pop,
    output logic                            redirect,
    output asrm_core_pkg::asrm_redirect_t   target,
    output logic                            halt,
    output logic                            running,
    output logic                            debug_valid,
    output logic [`ASRM_WORDSIZE-1:0]       debug_data
);

    localparam int W        = `ASRM_WORDSIZE;
    localparam int NUM_REGS = `ASRM_PC_ID;

    // registers 0 to 14, the program counter lives in the fetch unit
    logic [W-1:0] regs [0:NUM_REGS-1];

    asrm_isa_pkg::asrm_opcode_e      opcode;
    asrm_isa_pkg::asrm_sys_e         sys_op;
    asrm_isa_pkg::asrm_reg_id_t      operand;
    asrm_core_pkg::asrm_alu_result_t alu_result;
    logic [`ASRM_PROG_AW-1:0]        next_addr;
    logic [W-1:0]                    working_reg;
    logic [W-1:0]                    status_reg;
    logic [W-1:0]                    other_reg;
    logic                            is_slp;
    logic                            is_debug;
    logic                            pc_write;

    assign opcode  = asrm_isa_pkg::asrm_opcode_e'(head.inst[7:4]);
    assign sys_op  = asrm_isa_pkg::asrm_sys_e'(head.inst[3:0]);
    assign operand = head.inst[3:0];

    assign is_slp   = (opcode == asrm_isa_pkg::op_sys) && (sys_op == asrm_isa_pkg::sys_slp);
    assign is_debug = (opcode == asrm_isa_pkg::op_sys) && (sys_op == asrm_isa_pkg::sys_debug);

    // pc reads as the address after the current instruction
    assign next_addr   = head.addr + 1'b1;
    assign working_reg = regs[`ASRM_WR_ID];
    assign status_reg  = regs[`ASRM_SR_ID];
    assign other_reg   = (operand == `ASRM_PC_ID) ? {{(W-`ASRM_PROG_AW){1'b0}}, next_addr}
                                                  : regs[operand];

    asrm_alu i_asrm_alu (
        .working_register (working_reg),
        .other_register   (other_reg),
        .status_register  (status_reg),
        .instruction      (head.inst),
        .result           (alu_result)
    );

    // one instruction per cycle whenever the queue has one
    assign pop      = running && not_empty;
    assign pc_write = (alu_result.dest == `ASRM_PC_ID);

    assign redirect    = pop && pc_write;
    assign target      = alu_result.value[`ASRM_PROG_AW-1:0];
    assign halt        = pop && is_slp;
    assign debug_valid = pop && is_debug;
    assign debug_data  = working_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else if (start && !running) begin
            running <= 1'b1;
        end else if (halt) begin
            running <= 1'b0;
        end
    end

    // start wipes the whole register file
    always_ff @(posedge clk) begin
        if (start && !running) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (pop && !pc_write) begin
            regs[alu_result.dest] <= alu_result.value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/asrm_fetch.sv
// ASRM fetch unit
// program memory and prefetch address

`default_nettype none

`include "asrm_settings.svh"

module asrm_fetch (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            prog_we,
    input  asrm_core_pkg::asrm_prog_write_t prog,
    input  logic                            redirect,
    input  asrm_core_pkg::asrm_redirect_t   target,
    input  logic                            halt,
    input  logic [2:0]                      fifo_count,
    output logic                            push,
    output asrm_core_pkg::asrm_fetch_item_t item
);

    localparam logic [3:0] FIFO_DEPTH = 4'(`ASRM_FIFO_DEPTH);

    logic [7:0]               prog_mem [0:`ASRM_PROG_DEPTH-1];
    logic [`ASRM_PROG_AW-1:0] fetch_addr;
    logic                     active;
    logic                     in_flight;
    logic                     room;
    logic                     issue;

    // queue entries plus the read still on its way must fit
    assign room  = ({1'b0, fifo_count} + {3'b000, in_flight}) < FIFO_DEPTH;
    assign issue = active && room && !redirect && !halt;
    assign push  = in_flight;

    // memory comes out of reset full of sleep instructions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `ASRM_PROG_DEPTH; i++) begin
                prog_mem[i] <= {asrm_isa_pkg::op_sys, asrm_isa_pkg::sys_slp};
            end
        end else if (prog_we && !active) begin
            prog_mem[prog.addr] <= prog.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active     <= 1'b0;
            in_flight  <= 1'b0;
            fetch_addr <= '0;
        end else if (start && !active) begin
            active     <= 1'b1;
            in_flight  <= 1'b0;
            fetch_addr <= '0;
        end else if (halt) begin
            active    <= 1'b0;
            in_flight <= 1'b0;
        end else if (redirect) begin
            // pending read is stale, restart at the jump target
            in_flight  <= 1'b0;
            fetch_addr <= target.addr;
        end else begin
            in_flight <= issue;
            if (issue) begin
                fetch_addr <= fetch_addr + 1'b1;
            end
        end
    end

    // synchronous read, item valid while in_flight is set
    always_ff @(posedge clk) begin
        if (issue) begin
            item.inst <= prog_mem[fetch_addr];
            item.addr <= fetch_addr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/asrm_inst_fifo.sv
// ASRM prefetch queue

`default_nettype none

`include "asrm_settings.svh"

module asrm_inst_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            push,
    input  asrm_core_pkg::asrm_fetch_item_t item,
    input  logic                            pop,
    input  logic                            flush,
    output asrm_core_pkg::asrm_fetch_item_t head,
    output logic                            not_empty,
    output logic [2:0]                      count
);

    localparam int AW = $clog2(`ASRM_FIFO_DEPTH);
    localparam logic [2:0] DEPTH = 3'(`ASRM_FIFO_DEPTH);

    asrm_core_pkg::asrm_fetch_item_t entries [0:`ASRM_FIFO_DEPTH-1];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign not_empty = (count != 3'd0);
    assign head      = entries[rd_ptr];

    // a push during flush belongs to the discarded stream
    assign do_push = push && !flush && (count != DEPTH);
    assign do_pop  = pop && !flush && not_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 3'd0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 3'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {2'b00, do_push} - {2'b00, do_pop};
        end
    end

    // storage, pointers say what is valid
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= item;
        end
    end

endmodule

`default_nettype wire

// File: hdl/asrm_isa_pkg.sv
// ASRM instruction set

`default_nettype none

package asrm_isa_pkg;

    // upper nibble of an instruction
    typedef enum logic [3:0] {
        op_sys  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_not  = 4'h6,
        op_lsl  = 4'h7,
        op_lsr  = 4'h8,
        op_cpy  = 4'h9,
        op_set  = 4'ha,
        op_read = 4'hb,
        op_eq   = 4'hc,
        op_les  = 4'hd
    } asrm_opcode_e;

    // low nibble when the opcode is op_sys
    typedef enum logic [3:0] {
        sys_nop   = 4'h0,
        sys_slp   = 4'h1,
        sys_jmp   = 4'h2,
        sys_jif   = 4'h3,
        sys_debug = 4'h4
    } asrm_sys_e;

    // register index, also the operand nibble of most opcodes
    typedef logic [3:0] asrm_reg_id_t;

endpackage

`default_nettype wire

// File: hdl/asrm_settings.svh
// ASRM core build settings

`ifndef ASRM_SETTINGS_SVH
`define ASRM_SETTINGS_SVH

// data path width
`define ASRM_WORDSIZE 16

// program memory, one instruction byte per entry
`define ASRM_PROG_DEPTH 256
`define ASRM_PROG_AW 8

// prefetch queue entries, keep a power of two
`define ASRM_FIFO_DEPTH 4

// register ids with a fixed role
// working register, source and target of most operations
`define ASRM_WR_ID 4'd0
// status register, bit 0 holds the last compare
`define ASRM_SR_ID 4'd14
// program counter, not stored in the register file
`define ASRM_PC_ID 4'd15

`endif

// File: hdl/asrm_top.sv
// ASRM core top level

`default_nettype none

`include "asrm_settings.svh"

module asrm_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            prog_we,
    input  asrm_core_pkg::asrm_prog_write_t prog,
    output logic                            running,
    output logic                            halted,
    output logic                            debug_valid,
    output logic [`ASRM_WORDSIZE-1:0]       debug_data
);

    asrm_core_pkg::asrm_fetch_item_t fetch_item;
    asrm_core_pkg::asrm_fetch_item_t queue_head;
    asrm_core_pkg::asrm_redirect_t   redirect_target;
    logic       fetch_push;
    logic       queue_pop;
    logic       queue_not_empty;
    logic [2:0] queue_count;
    logic       redirect;
    logic       queue_flush;

    // both jumps and sleep throw away the prefetched stream
    assign queue_flush = redirect | halted;

    asrm_fetch i_asrm_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .prog_we    (prog_we),
        .prog       (prog),
        .redirect   (redirect),
        .target     (redirect_target),
        .halt       (halted),
        .fifo_count (queue_count),
        .push       (fetch_push),
        .item       (fetch_item)
    );

    asrm_inst_fifo i_asrm_inst_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fetch_push),
        .item      (fetch_item),
        .pop       (queue_pop),
        .flush     (queue_flush),
        .head      (queue_head),
        .not_empty (queue_not_empty),
        .count     (queue_count)
    );

    asrm_exec i_asrm_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .head        (queue_head),
        .not_empty   (queue_not_empty),
        .pop         (queue_pop),
        .redirect    (redirect),
        .target      (redirect_target),
        .halt        (halted),
        .running     (running),
        .debug_valid (debug_valid),
        .debug_data  (debug_data)
    );

endmodule

`default_nettype wire

// File: verification/asrm_tb.sv
// ASRM core testbench
// random programs against an ISA model

`default_nettype none

`include "asrm_settings.svh"

module asrm_tb;

    localparam int W           = `ASRM_WORDSIZE;
    localparam int PROG_LEN    = 64;
    localparam int NUM_PROGS   = 20;
    localparam int MAX_STEPS   = 1000;
    localparam int DRIVE_DELAY = 2;

    logic                            clk;
    logic                            rst_n;
    logic                            start;
    logic                            prog_we;
    asrm_core_pkg::asrm_prog_write_t prog;
    logic                            running;
    logic                            halted;
    logic                            debug_valid;
    logic [W-1:0]                    debug_data;

    logic [31:0]  lfsr_state;
    logic [7:0]   program_mem [0:`ASRM_PROG_DEPTH-1];
    logic [W-1:0] expected_debug [$];
    int           prog_index;
    int           debug_index;
    int           halt_count;
    int           value_errors;
    int           protocol_errors;
    bit           timed_out;

    asrm_top i_asrm_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .prog_we     (prog_we),
        .prog        (prog),
        .running     (running),
        .halted      (halted),
        .debug_valid (debug_valid),
        .debug_data  (debug_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] take_nibble();
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < 4; i++) begin
            v = {v[2:0], take_bit()};
        end
        return v;
    endfunction

    task automatic next_drive();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_word(input string name, input logic [W-1:0] expected,
                                input logic [W-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // weighted mix of debug, set, ALU ops, moves, compares and jumps
    task automatic build_program();
        logic [3:0] kind;
        logic [3:0] nib;
        logic [3:0] alu_op;
        for (int a = 0; a < `ASRM_PROG_DEPTH; a++) begin
            program_mem[a] = {asrm_isa_pkg::op_sys, asrm_isa_pkg::sys_slp};
        end
        for (int a = 0; a < PROG_LEN - 1; a++) begin
            kind   = take_nibble();
            nib    = take_nibble();
            alu_op = 4'd1 + (take_nibble() & 4'h7);
            case (kind)
                4'd0, 4'd1, 4'd2: program_mem[a] = {asrm_isa_pkg::op_sys, asrm_isa_pkg::sys_debug};
                4'd3, 4'd4:       program_mem[a] = {asrm_isa_pkg::op_set, nib};
                4'd5, 4'd6, 4'd7: program_mem[a] = {alu_op, nib};
                4'd8:             program_mem[a] = {asrm_isa_pkg::op_read, nib};
                4'd9:             program_mem[a] = {asrm_isa_pkg::op_cpy, nib};
                4'd10:            program_mem[a] = {asrm_isa_pkg::op_eq, nib};
                4'd11:            program_mem[a] = {asrm_isa_pkg::op_les, nib};
                4'd12, 4'd13:     program_mem[a] = {asrm_isa_pkg::op_sys, asrm_isa_pkg::sys_jif};
                4'd14:            program_mem[a] = {asrm_isa_pkg::op_sys, asrm_isa_pkg::sys_jmp};
                default:          program_mem[a] = {asrm_isa_pkg::op_sys, asrm_isa_pkg::sys_nop};
            endcase
        end
    endtask

    // ISA interpreter, records the debug stream and stops at sleep
    task automatic run_model(output bit done, output int steps);
        logic [W-1:0] regs [0:14];
        logic [7:0]   pc;
        logic [7:0]   next_pc;
        logic [3:0]   op;
        logic [3:0]   nib;
        logic [W-1:0] wr;
        logic [W-1:0] other;
        done  = 1'b0;
        steps = 0;
        pc    = 8'd0;
        expected_debug.delete();
        for (int r = 0; r < 15; r++) begin
            regs[r] = '0;
        end
        while (!done && steps < MAX_STEPS) begin
            op      = program_mem[pc][7:4];
            nib     = program_mem[pc][3:0];
            wr      = regs[`ASRM_WR_ID];
            next_pc = pc + 8'd1;
            if (nib == `ASRM_PC_ID) begin
                other = {{(W-8){1'b0}}, next_pc};
            end else begin
                other = regs[nib];
            end
            steps++;
            case (op)
                asrm_isa_pkg::op_sys: begin
                    if (nib == asrm_isa_pkg::sys_slp) begin
                        done = 1'b1;
                    end else if (nib == asrm_isa_pkg::sys_jmp
                                 || (nib == asrm_isa_pkg::sys_jif && regs[`ASRM_SR_ID][0])) begin
                        next_pc = wr[7:0];
                    end else if (nib == asrm_isa_pkg::sys_debug) begin
                        expected_debug.push_back(wr);
                    end
                end
                asrm_isa_pkg::op_add:  regs[`ASRM_WR_ID] = wr + other;
                asrm_isa_pkg::op_sub:  regs[`ASRM_WR_ID] = wr - other;
                asrm_isa_pkg::op_and:  regs[`ASRM_WR_ID] = wr & other;
                asrm_isa_pkg::op_or:   regs[`ASRM_WR_ID] = wr | other;
                asrm_isa_pkg::op_xor:  regs[`ASRM_WR_ID] = wr ^ other;
                asrm_isa_pkg::op_not:  regs[`ASRM_WR_ID] = ~other;
                asrm_isa_pkg::op_lsl:  regs[`ASRM_WR_ID] = (other >= W) ? '0 : wr << other;
                asrm_isa_pkg::op_lsr:  regs[`ASRM_WR_ID] = (other >= W) ? '0 : wr >> other;
                asrm_isa_pkg::op_set:  regs[`ASRM_WR_ID] = {{(W-4){1'b0}}, nib};
                asrm_isa_pkg::op_read: regs[`ASRM_WR_ID] = other;
                asrm_isa_pkg::op_eq:   regs[`ASRM_SR_ID][0] = (wr == other);
                asrm_isa_pkg::op_les:  regs[`ASRM_SR_ID][0] = (wr < other);
                asrm_isa_pkg::op_cpy: begin
                    if (nib == `ASRM_PC_ID) begin
                        next_pc = wr[7:0];
                    end else begin
                        regs[nib] = wr;
                    end
                end
                default: ;
            endcase
            pc = next_pc;
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < PROG_LEN; a++) begin
            next_drive();
            prog_we   = 1'b1;
            prog.addr = 8'(a);
            prog.inst = program_mem[a];
        end
        next_drive();
        prog_we = 1'b0;
    endtask

    // strobes sampled mid-cycle, away from the drive edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (halted) begin
                halt_count++;
            end
            if (debug_valid) begin
                if (debug_index < expected_debug.size()) begin
                    compare_word($sformatf("program %0d debug %0d", prog_index, debug_index),
                                 expected_debug[debug_index], debug_data);
                end else begin
                    protocol_errors++;
                    $display("ERROR: program %0d gave an extra debug strobe with data %h",
                             prog_index, debug_data);
                end
                debug_index++;
            end
        end
    end

    initial begin
        int steps;
        int limit;
        int cycles;
        bit done;
        lfsr_state      = 32'd92148;
        rst_n           = 1'b0;
        start           = 1'b0;
        prog_we         = 1'b0;
        prog            = '0;
        debug_index     = 0;
        halt_count      = 0;
        value_errors    = 0;
        protocol_errors = 0;
        timed_out       = 1'b0;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (prog_index = 0; prog_index < NUM_PROGS && !timed_out; prog_index++) begin
            done = 1'b0;
            while (!done) begin
                build_program();
                run_model(done, steps);
            end
            load_program();
            debug_index = 0;
            halt_count  = 0;
            next_drive();
            start = 1'b1;
            next_drive();
            start = 1'b0;
            if (!running) begin
                protocol_errors++;
                $display("ERROR: program %0d did not raise running after start", prog_index);
            end
            // a taken jump costs at most three bubbles per step
            limit  = 4 * steps + 200;
            cycles = 0;
            while (halt_count == 0 && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            if (halt_count == 0) begin
                protocol_errors++;
                timed_out = 1'b1;
                $display("ERROR: program %0d gave no halted pulse within %0d cycles",
                         prog_index, limit);
            end else begin
                repeat (8) @(posedge clk);
                compare_count($sformatf("program %0d halt count", prog_index), 1, halt_count);
                compare_count($sformatf("program %0d debug count", prog_index),
                              expected_debug.size(), debug_index);
                if (running) begin
                    protocol_errors++;
                    $display("ERROR: program %0d left running high after halt", prog_index);
                end
            end
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
